// ==== hdl/dmm_cfg.svh ====
// clock, phase timing and data width macros for the multimeter sample sequencer
`ifndef DMM_CFG_SVH
`define DMM_CFG_SVH

//////////////////////////////////////////////////
// timing

// system clock in hz, periods below are in clocks of this
`define DMM_CLK_FREQ      20000000

// precharge / protect pause, kept short for simulation
// a board build would use something near DMM_CLK_FREQ * 500e-6
`define DMM_PRECHARGE_N   40

// integration aperture of the adc
`define DMM_APERTURE_N    32

//////////////////////////////////////////////////
// widths

// signed input code fed to the adc model
`define DMM_CODE_W        16
// signed accumulated result, must hold code * aperture
`define DMM_RESULT_W      24
// phase down-counters
`define DMM_COUNT_W       24

`endif

// ==== hdl/dmm_pkg.sv ====
// shared enums: sampling mode, azmux and precharge switch positions, FSM states
`default_nettype none

package dmm_pkg;

  // run-time sampling mode
  typedef enum logic {
    MODE_NO_AZ = 1'b0,
    MODE_AZ    = 1'b1
  } mode_t;

  // autozero mux, lo is the safe position
  typedef enum logic {
    AZMUX_LO = 1'b0,
    AZMUX_HI = 1'b1
  } azmux_t;

  // precharge switch, boot protects the signal from charge injection
  typedef enum logic {
    SW_PC_BOOT   = 1'b0,
    SW_PC_SIGNAL = 1'b1
  } sw_pc_t;

  // no-autozero sequencer
  typedef enum logic [2:0] {
    NO_AZ_START,
    NO_AZ_PC_LOAD,
    NO_AZ_PC_WAIT,
    NO_AZ_TRIG,
    NO_AZ_ADC_WAIT
  } no_az_state_t;

  // autozero sequencer
  typedef enum logic [3:0] {
    AZ_START,
    AZ_PROTECT,
    AZ_PROTECT_WAIT,
    AZ_PRECHARGE,
    AZ_PRECHARGE_WAIT,
    AZ_HI_TRIG,
    AZ_HI_WAIT,
    AZ_LO_TRIG,
    AZ_LO_WAIT
  } az_state_t;

  // controller capture, remembers that a hi result is held
  typedef enum logic {
    CTL_IDLE,
    CTL_HI_CAPT
  } ctl_state_t;

endpackage

`default_nettype wire

// ==== hdl/adc_if.sv ====
// adc_if: trigger, mux select, valid strobe and result between controller and adc
`default_nettype none

`include "dmm_cfg.svh"

interface adc_if ();

  import dmm_pkg::*;

  // one cycle measure request
  logic                             trig;
  // input select, held for the whole aperture
  azmux_t                           azmux;
  // one cycle done strobe
  logic                             valid;
  // stable from valid until the next trig
  logic signed [`DMM_RESULT_W-1:0]  result;

  modport ctl (
    output trig,
    output azmux,
    input  valid,
    input  result
  );

  modport adc (
    input  trig,
    input  azmux,
    output valid,
    output result
  );

endinterface

`default_nettype wire

// ==== hdl/seq_if.sv ====
// seq_if: switch, trigger and monitor outputs of one sequencer, run and valid back
`default_nettype none

interface seq_if ();

  import dmm_pkg::*;

  // sequencer side
  logic         trig;
  azmux_t       azmux;
  sw_pc_t       sw_pc;
  logic         led0;
  logic [1:0]   monitor;
  // high while a hi measurement is in flight
  logic         hi_phase;

  // controller side
  // level, sequencer may leave start only while high
  logic         run;
  // adc valid, only ever returned to the active sequencer
  logic         valid;

  modport seq (
    output trig,
    output azmux,
    output sw_pc,
    output led0,
    output monitor,
    output hi_phase,
    input  run,
    input  valid
  );

  modport ctl (
    input  trig,
    input  azmux,
    input  sw_pc,
    input  led0,
    input  monitor,
    input  hi_phase,
    output run,
    output valid
  );

endinterface

`default_nettype wire

// ==== hdl/adc_measure.sv ====
// adc_measure: integrating adc model summing the selected code over a fixed aperture
`default_nettype none

`include "dmm_cfg.svh"

module adc_measure (
  input  logic                          clk,
  input  logic                          reset,
  adc_if.adc                            bus,
  input  logic signed [`DMM_CODE_W-1:0] code_hi,
  input  logic signed [`DMM_CODE_W-1:0] code_lo
);

  import dmm_pkg::*;

  localparam logic [`DMM_COUNT_W-1:0] APERTURE_N = `DMM_APERTURE_N;
  localparam logic [`DMM_COUNT_W-1:0] LAST_N     = 1;

  logic [`DMM_COUNT_W-1:0]          count_down;
  logic                             busy;
  logic signed [`DMM_RESULT_W-1:0]  acc;
  // selected code, sign extended to accumulator width
  logic signed [`DMM_RESULT_W-1:0]  code_ext;

  assign code_ext = (bus.azmux == AZMUX_HI) ? code_hi : code_lo;

  //////////////////////////////////////////////////
  // aperture counter and accumulator

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count_down <= '0;
      busy       <= 1'b0;
      acc        <= '0;
      bus.valid  <= 1'b0;
    end
    else
    begin
      // valid is a strobe
      bus.valid <= 1'b0;

      if (bus.trig)
      begin
        // start of aperture, old result is dropped here
        acc        <= '0;
        count_down <= APERTURE_N;
        busy       <= 1'b1;
      end
      else if (busy)
      begin
        // one code per clock of the aperture
        acc        <= acc + code_ext;
        count_down <= count_down - 1'b1;

        // last add, counter hits zero on this edge
        if (count_down == LAST_N)
        begin
          busy      <= 1'b0;
          bus.valid <= 1'b1;
        end
      end
    end
  end

  // accumulator doubles as the held result
  assign bus.result = acc;

  // the controller must wait for valid before the next request
  a_no_trig_while_busy: assert property (
    @(posedge clk) disable iff (reset) bus.trig |-> !busy
  );

endmodule

`default_nettype wire

// ==== hdl/sample_modulation_no_az.sv ====
// sample_modulation_no_az: precharge pause, adc trigger and valid wait, looped
`default_nettype none

`include "dmm_cfg.svh"

module sample_modulation_no_az (
  input  logic  clk,
  input  logic  reset,
  seq_if.seq    bus
);

  import dmm_pkg::*;

  localparam logic [`DMM_COUNT_W-1:0] PRECHARGE_N = `DMM_PRECHARGE_N;

  no_az_state_t             state;
  // clocks left in the current pause
  logic [`DMM_COUNT_W-1:0]  count_down;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= NO_AZ_START;
      count_down   <= '0;
      bus.trig     <= 1'b0;
      bus.azmux    <= AZMUX_LO;
      bus.sw_pc    <= SW_PC_BOOT;
      bus.led0     <= 1'b0;
      bus.monitor  <= 2'b00;
      bus.hi_phase <= 1'b0;
    end
    else
    begin
      case (state)

        // parked until the controller hands over the adc
        NO_AZ_START:
          if (bus.run)
          begin
            state          <= NO_AZ_PC_LOAD;
            bus.monitor[0] <= 1'b0;
            // mux moves first, while still protected
            bus.azmux      <= AZMUX_HI;
          end
          else
          begin
            bus.monitor[0] <= 1'b1;
            bus.azmux      <= AZMUX_LO;
          end

        //////////////////////////////////////////////////
        // pause matching the az precharge, keeps sample rate similar
        NO_AZ_PC_LOAD:
          begin
            state      <= NO_AZ_PC_WAIT;
            count_down <= PRECHARGE_N;
            // input is always the signal without autozero
            bus.sw_pc  <= SW_PC_SIGNAL;
            // one toggle per sample, visible at the bench
            bus.led0   <= ~bus.led0;
          end

        NO_AZ_PC_WAIT:
          if (count_down == '0)
            state <= NO_AZ_TRIG;
          else
            count_down <= count_down - 1'b1;

        //////////////////////////////////////////////////
        // measure
        NO_AZ_TRIG:
          begin
            state          <= NO_AZ_ADC_WAIT;
            bus.trig       <= 1'b1;
            bus.monitor[1] <= 1'b1;
            bus.hi_phase   <= 1'b1;
          end

        NO_AZ_ADC_WAIT:
          begin
            bus.trig       <= 1'b0;
            bus.monitor[1] <= 1'b0;
            if (!bus.trig && bus.valid)
            begin
              bus.hi_phase <= 1'b0;
              if (bus.run)
                state <= NO_AZ_PC_LOAD;
              else
              begin
                // handing over, protect before the mux returns to lo
                state     <= NO_AZ_START;
                bus.sw_pc <= SW_PC_BOOT;
              end
            end
          end

        default:
          state <= NO_AZ_START;

      endcase
    end
  end

  // trigger is a single clock strobe
  a_trig_one_cycle: assert property (
    @(posedge clk) disable iff (reset) bus.trig |=> !bus.trig
  );

endmodule

`default_nettype wire

// ==== hdl/sample_modulation_az.sv ====
// sample_modulation_az: autozero sequence of protect, precharge, hi and lo measurements
`default_nettype none

`include "dmm_cfg.svh"

module sample_modulation_az (
  input  logic  clk,
  input  logic  reset,
  seq_if.seq    bus
);

  import dmm_pkg::*;

  // wait state runs count..0, so load one less for a full pause
  localparam logic [`DMM_COUNT_W-1:0] WAIT_N = `DMM_PRECHARGE_N - 1;

  az_state_t                state;
  logic [`DMM_COUNT_W-1:0]  count_down;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= AZ_START;
      count_down   <= '0;
      bus.trig     <= 1'b0;
      bus.azmux    <= AZMUX_LO;
      bus.sw_pc    <= SW_PC_BOOT;
      bus.led0     <= 1'b0;
      bus.monitor  <= 2'b00;
      bus.hi_phase <= 1'b0;
    end
    else
    begin
      case (state)

        // run only checked here, a started sample always completes
        AZ_START:
          if (bus.run)
          begin
            state          <= AZ_PROTECT;
            bus.monitor[0] <= 1'b0;
          end
          else
            bus.monitor[0] <= 1'b1;

        //////////////////////////////////////////////////
        // precharge switch to boot, protects the signal from
        // the charge injection of the az switch
        AZ_PROTECT:
          begin
            state      <= AZ_PROTECT_WAIT;
            count_down <= WAIT_N;
            bus.sw_pc  <= SW_PC_BOOT;
          end

        // mux still at hi means the hi measurement is done
        AZ_PROTECT_WAIT:
          if (count_down == '0)
            state <= (bus.azmux == AZMUX_HI) ? AZ_LO_TRIG : AZ_PRECHARGE;
          else
            count_down <= count_down - 1'b1;

        //////////////////////////////////////////////////
        // azmux lo -> hi, settle against the boot buffer
        AZ_PRECHARGE:
          begin
            state      <= AZ_PRECHARGE_WAIT;
            count_down <= WAIT_N;
            bus.azmux  <= AZMUX_HI;
            bus.led0   <= ~bus.led0;
          end

        AZ_PRECHARGE_WAIT:
          if (count_down == '0)
            state <= AZ_HI_TRIG;
          else
            count_down <= count_down - 1'b1;

        //////////////////////////////////////////////////
        // pc switch boot -> signal, take hi
        AZ_HI_TRIG:
          begin
            state          <= AZ_HI_WAIT;
            bus.sw_pc      <= SW_PC_SIGNAL;
            bus.trig       <= 1'b1;
            bus.monitor[1] <= 1'b1;
            bus.hi_phase   <= 1'b1;
          end

        AZ_HI_WAIT:
          begin
            bus.trig       <= 1'b0;
            bus.monitor[1] <= 1'b0;
            if (!bus.trig && bus.valid)
            begin
              // protect again before the mux moves back to lo
              state        <= AZ_PROTECT;
              bus.hi_phase <= 1'b0;
            end
          end

        //////////////////////////////////////////////////
        // azmux to lo, take lo with signal still protected
        AZ_LO_TRIG:
          begin
            state          <= AZ_LO_WAIT;
            bus.azmux      <= AZMUX_LO;
            bus.trig       <= 1'b1;
            bus.monitor[1] <= 1'b1;
          end

        AZ_LO_WAIT:
          begin
            bus.trig       <= 1'b0;
            bus.monitor[1] <= 1'b0;
            if (!bus.trig && bus.valid)
              state <= AZ_START;
          end

        default:
          state <= AZ_START;

      endcase
    end
  end

  // mux only moves with the signal protected, before and after the edge
  a_azmux_protected: assert property (
    @(posedge clk) disable iff (reset)
    !$stable(bus.azmux) |-> ($past(bus.sw_pc) == SW_PC_BOOT && bus.sw_pc == SW_PC_BOOT)
  );

endmodule

`default_nettype wire

// ==== hdl/sample_controller.sv ====
// sample_controller: mode hand-over, adc routing, hi/lo capture and result strobe
`default_nettype none

`include "dmm_cfg.svh"

module sample_controller (
  input  logic                            clk,
  input  logic                            reset,
  input  dmm_pkg::mode_t                  mode,
  seq_if.ctl                              no_az,
  seq_if.ctl                              az,
  adc_if.ctl                              adc,
  output logic signed [`DMM_RESULT_W-1:0] result,
  output logic                            sample_ready,
  output logic                            led0,
  output logic [1:0]                      monitor,
  output dmm_pkg::sw_pc_t                 sw_pc,
  output dmm_pkg::azmux_t                 azmux
);

  import dmm_pkg::*;

  // mode owning the adc, and mode requested by the host
  mode_t                            active;
  mode_t                            target;
  ctl_state_t                       ctl_state;
  // trigs issued minus valids returned
  logic [1:0]                       in_flight;
  logic                             act_az;
  logic                             act_hi_phase;
  logic                             act_parked;
  logic                             switch_ok;
  logic signed [`DMM_RESULT_W-1:0]  hi_q;

  //////////////////////////////////////////////////
  // routing

  assign act_az = (active == MODE_AZ);

  // run drops for the old owner as soon as a change is pending
  assign no_az.run   = !act_az && (target == active);
  assign az.run      = act_az && (target == active);
  assign no_az.valid = adc.valid && !act_az;
  assign az.valid    = adc.valid && act_az;

  assign adc.trig  = act_az ? az.trig : no_az.trig;
  assign adc.azmux = act_az ? az.azmux : no_az.azmux;

  assign sw_pc   = act_az ? az.sw_pc : no_az.sw_pc;
  assign azmux   = act_az ? az.azmux : no_az.azmux;
  assign led0    = act_az ? az.led0 : no_az.led0;
  assign monitor = act_az ? az.monitor : no_az.monitor;

  assign act_hi_phase = act_az ? az.hi_phase : no_az.hi_phase;
  // monitor[0] is set only while a sequencer sits in start with run low
  assign act_parked   = act_az ? az.monitor[0] : no_az.monitor[0];

  // hand over only with the adc quiet and the old owner parked
  assign switch_ok = (target != active) && (in_flight == 2'd0)
                     && (ctl_state == CTL_IDLE) && act_parked;

  //////////////////////////////////////////////////
  // mode, in-flight count and sample capture

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      active       <= MODE_NO_AZ;
      target       <= MODE_NO_AZ;
      ctl_state    <= CTL_IDLE;
      in_flight    <= 2'd0;
      result       <= '0;
      sample_ready <= 1'b0;
    end
    else
    begin
      sample_ready <= 1'b0;

      // mode input only looked at between measurements
      if (in_flight == 2'd0)
        target <= mode;
      if (switch_ok)
        active <= target;

      if (adc.trig)
        in_flight <= in_flight + 2'd1;
      else if (adc.valid)
        in_flight <= in_flight - 2'd1;

      if (adc.valid)
      begin
        if (!act_az)
        begin
          // no autozero, every valid is a sample
          result       <= adc.result;
          sample_ready <= 1'b1;
        end
        else if (act_hi_phase)
          ctl_state <= CTL_HI_CAPT;
        else if (ctl_state == CTL_HI_CAPT)
        begin
          // lo completes the az sample
          result       <= hi_q - adc.result;
          sample_ready <= 1'b1;
          ctl_state    <= CTL_IDLE;
        end
      end
    end
  end

  // hi measurement held for the subtraction
  always_ff @(posedge clk)
  begin
    if (adc.valid && act_az && act_hi_phase)
      hi_q <= adc.result;
  end

  // every no-az measurement is a hi measurement
  a_no_az_valid_hi: assert property (
    @(posedge clk) disable iff (reset) (adc.valid && !act_az) |-> act_hi_phase
  );

endmodule

`default_nettype wire

// ==== hdl/dmm_top.sv ====
// dmm_top: two sequencers, sample controller and adc model wired through interfaces
`default_nettype none

`include "dmm_cfg.svh"

module dmm_top (
  input  logic                            clk,
  input  logic                            reset,
  input  dmm_pkg::mode_t                  mode,
  input  logic signed [`DMM_CODE_W-1:0]   code_hi,
  input  logic signed [`DMM_CODE_W-1:0]   code_lo,
  output logic signed [`DMM_RESULT_W-1:0] result,
  output logic                            sample_ready,
  output logic                            led0,
  output logic [1:0]                      monitor,
  output dmm_pkg::sw_pc_t                 sw_pc,
  output dmm_pkg::azmux_t                 azmux
);

  // shared adc, one link per sequencer
  adc_if u_adc_if ();
  seq_if u_no_az_if ();
  seq_if u_az_if ();

  sample_modulation_no_az u_no_az (
    .clk   (clk),
    .reset (reset),
    .bus   (u_no_az_if.seq)
  );

  sample_modulation_az u_az (
    .clk   (clk),
    .reset (reset),
    .bus   (u_az_if.seq)
  );

  sample_controller u_ctl (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .no_az        (u_no_az_if.ctl),
    .az           (u_az_if.ctl),
    .adc          (u_adc_if.ctl),
    .result       (result),
    .sample_ready (sample_ready),
    .led0         (led0),
    .monitor      (monitor),
    .sw_pc        (sw_pc),
    .azmux        (azmux)
  );

  adc_measure u_adc (
    .clk     (clk),
    .reset   (reset),
    .bus     (u_adc_if.adc),
    .code_hi (code_hi),
    .code_lo (code_lo)
  );

endmodule

`default_nettype wire

// ==== bench/tb_dmm_top.sv ====
// tb_dmm_top: clock, reset, random codes, mode schedule, reference model, checker, watchdog
`default_nettype none

`include "dmm_cfg.svh"

module tb_dmm_top;

  import dmm_pkg::*;

  //////////////////////////////////////////////////
  // run length

  localparam int NO_AZ_RUN     = 12;
  // first sample after a change still belongs to the old mode, so 12 az plus one
  localparam int AZ_RUN        = 13;
  localparam int SWITCH_RUN    = 5;
  localparam int TOTAL_SAMPLES = NO_AZ_RUN + AZ_RUN + 2 * SWITCH_RUN;
  localparam int SAMPLE_CYCLES = 2 * `DMM_PRECHARGE_N + 2 * `DMM_APERTURE_N + 20;
  // factor 2 covers the longer az sample and the hand-over gaps
  localparam int WATCHDOG_CYCLES = 2 * (TOTAL_SAMPLES + 2) * SAMPLE_CYCLES + 20;

  logic                             clk;
  logic                             reset;
  mode_t                            mode;
  logic signed [`DMM_CODE_W-1:0]    code_hi;
  logic signed [`DMM_CODE_W-1:0]    code_lo;
  logic signed [`DMM_RESULT_W-1:0]  result;
  logic                             sample_ready;
  logic                             led0;
  logic [1:0]                       monitor;
  sw_pc_t                           sw_pc;
  azmux_t                           azmux;

  int errors       = 0;
  int checks       = 0;
  int samples_seen = 0;
  int ready_pulses = 0;
  int az_seen      = 0;
  int exp_az       = 0;

  // checker state, pins as seen on the previous falling edge
  mode_t   sample_mode;
  mode_t   prev_sample_mode;
  azmux_t  last_azmux;
  sw_pc_t  last_sw_pc;
  logic    last_led0;
  logic    last_ready;
  logic    last_mon1;
  int      led_toggles;
  int      trig_pulses;
  logic    saw_hi;
  logic    saw_lo;

  dmm_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .mode         (mode),
    .code_hi      (code_hi),
    .code_lo      (code_lo),
    .result       (result),
    .sample_ready (sample_ready),
    .led0         (led0),
    .monitor      (monitor),
    .sw_pc        (sw_pc),
    .azmux        (azmux)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference and error helpers

  // adc sums one code per aperture clock, az subtracts the lo sum
  function automatic logic signed [`DMM_RESULT_W-1:0] expected_result(
    input mode_t                          m,
    input logic signed [`DMM_CODE_W-1:0]  hi,
    input logic signed [`DMM_CODE_W-1:0]  lo
  );
    longint sum;
    if (m == MODE_AZ)
      sum = (longint'(hi) - longint'(lo)) * `DMM_APERTURE_N;
    else
      sum = longint'(hi) * `DMM_APERTURE_N;
    return sum[`DMM_RESULT_W-1:0];
  endfunction

  task automatic flag_mismatch(
    input string                    name,
    input logic [`DMM_RESULT_W-1:0] got,
    input logic [`DMM_RESULT_W-1:0] exp
  );
    errors = errors + 1;
    $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  task automatic note_failure(input string msg);
    errors = errors + 1;
    $display("%s", msg);
  endtask

  // every control output parked
  task automatic check_reset_outputs();
    checks = checks + 6;
    assert (sample_ready === 1'b0) else flag_mismatch("sample_ready", sample_ready, 0);
    assert (led0 === 1'b0) else flag_mismatch("led0", led0, 0);
    assert (monitor === 2'b00) else flag_mismatch("monitor", monitor, 0);
    assert (result === '0) else flag_mismatch("result", result, 0);
    assert (sw_pc === SW_PC_BOOT) else flag_mismatch("sw_pc", sw_pc, SW_PC_BOOT);
    assert (azmux === AZMUX_LO) else flag_mismatch("azmux", azmux, AZMUX_LO);
  endtask

  //////////////////////////////////////////////////
  // checker, all pins read on the falling edge

  task automatic check_sample();
    logic signed [`DMM_RESULT_W-1:0] expected;
    expected = expected_result(sample_mode, code_hi, code_lo);
    checks = checks + 1;
    assert (result === expected)
    else
      flag_mismatch("result", result, expected);
    // top led0 follows the active sequencer, so hand-over intervals are skipped
    if (sample_mode == prev_sample_mode)
    begin
      checks = checks + 1;
      assert (led_toggles == 1)
      else
        note_failure($sformatf("led0 toggled %0d times in sample %0d instead of once",
                               led_toggles, samples_seen));
    end
    if (sample_mode == MODE_AZ)
    begin
      checks = checks + 1;
      assert (saw_hi && saw_lo)
      else
        note_failure($sformatf("azmux not seen both hi and lo in az sample %0d",
                               samples_seen));
    end
    // two trigger pulses on monitor[1] mark a hi plus lo sample
    if (trig_pulses == 2)
      az_seen = az_seen + 1;
    samples_seen     = samples_seen + 1;
    prev_sample_mode = sample_mode;
    // the next sample has already begun under the mode now applied
    sample_mode      = mode;
    led_toggles      = 0;
    trig_pulses      = 0;
    saw_hi           = 1'b0;
    saw_lo           = 1'b0;
  endtask

  always @(negedge clk)
  begin
    if (reset)
    begin
      last_azmux       = azmux;
      last_sw_pc       = sw_pc;
      last_led0        = led0;
      last_ready       = sample_ready;
      last_mon1        = monitor[1];
      led_toggles      = 0;
      trig_pulses      = 0;
      saw_hi           = 1'b0;
      saw_lo           = 1'b0;
      sample_mode      = mode;
      prev_sample_mode = mode;
    end
    else
    begin
      // charge injection rule, mux moves only with the signal protected
      if (azmux !== last_azmux)
      begin
        checks = checks + 1;
        assert (last_sw_pc == SW_PC_BOOT && sw_pc == SW_PC_BOOT)
        else
          note_failure("azmux changed while sw_pc was at signal");
      end
      if (sample_ready && !last_ready)
        ready_pulses = ready_pulses + 1;
      if (sample_ready)
        check_sample();
      // a toggle on the ready edge is counted toward the next sample
      if (led0 !== last_led0)
        led_toggles = led_toggles + 1;
      if (monitor[1] && !last_mon1)
        trig_pulses = trig_pulses + 1;
      if (azmux == AZMUX_HI)
        saw_hi = 1'b1;
      else
        saw_lo = 1'b1;
      last_azmux = azmux;
      last_sw_pc = sw_pc;
      last_led0  = led0;
      last_ready = sample_ready;
      last_mon1  = monitor[1];
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  task automatic new_codes();
    code_hi = $urandom();
    code_lo = $urandom();
  endtask

  // returns 1 unit after the rising edge that follows a ready pulse
  task automatic wait_ready();
    do
      @(negedge clk);
    while (!sample_ready);
    @(posedge clk);
    #1;
  endtask

  // apply a mode, then take n samples with fresh codes after each
  task automatic run_segment(input mode_t m, input int n);
    mode_t old_mode;
    old_mode = mode;
    mode     = m;
    for (int i = 0; i < n; i++)
    begin
      if ((i == 0 ? old_mode : m) == MODE_AZ)
        exp_az = exp_az + 1;
      wait_ready();
      new_codes();
    end
  endtask

  initial
  begin
    void'($urandom(77726));
    reset = 1'b1;
    mode  = MODE_NO_AZ;
    new_codes();

    // 8 rising edges in reset, outputs checked between them
    repeat (7)
    begin
      @(negedge clk);
      check_reset_outputs();
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_reset_outputs();

    run_segment(MODE_NO_AZ, NO_AZ_RUN);
    run_segment(MODE_AZ, AZ_RUN);
    // hand-over both ways again
    run_segment(MODE_NO_AZ, SWITCH_RUN);
    run_segment(MODE_AZ, SWITCH_RUN);

    checks = checks + 2;
    assert (ready_pulses == TOTAL_SAMPLES)
    else
      note_failure($sformatf("saw %0d ready pulses, expected %0d samples",
                             ready_pulses, TOTAL_SAMPLES));
    assert (az_seen == exp_az)
    else
      note_failure($sformatf("saw %0d autozero samples, expected %0d", az_seen, exp_az));

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/dmm_pkg.sv
hdl/adc_if.sv
hdl/seq_if.sv
hdl/adc_measure.sv
hdl/sample_modulation_no_az.sv
hdl/sample_modulation_az.sv
hdl/sample_controller.sv
hdl/dmm_top.sv
bench/tb_dmm_top.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the multimeter sample sequencer
TOP = tb_dmm_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)

# pass only if the pass line appears in the simulator output
run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
